/* uart_sync.f */
+incdir+.
uart_pkg.sv
uart_bit_timer.sv
uart_tx_ctrl.sv
uart_tx_shift.sv
uart_rx_ctrl.sv
uart_rx_shift.sv
uart_sync_top.sv
tb_uart_sync.sv

/* uart_stimulus.txt */
# mode data frame_err, one item per line
# L loopback, F frame with a low stop bit on rxd, G short low glitch on rxd
L 55 0
L a3 0
L 00 0
L ff 0
F 5a 1
L 01 0
L 80 0
G 00 0
L 3c 0
L c5 0
F 0f 1
G 00 0
L 7e 0
L 96 0
F e1 1
G 00 0

/* tb_uart_sync.sv */
// UART testbench
`timescale 1ns/1ps
`include "uart_config.svh"

module tb_uart_sync;
    import uart_pkg::*;

    localparam int D      = `UART_CLK_DIVISOR;
    localparam int W      = `UART_DATA_WIDTH;
    localparam int BITS   = W + 2;
    localparam int GLITCH = (D / 4 > 1) ? D / 4 - 1 : 1;

    logic       clk;
    logic       rst_n;
    data_t      tx_data;
    logic       tx_valid;
    logic       tx_ready;
    logic       txd;
    logic       rxd;
    logic       rxd_drv;
    logic       loop_mode;
    data_t      rx_data;
    logic       rx_valid;
    logic       frame_err;

    logic [7:0] mode_q[$];
    data_t      word_q[$];
    logic       ferr_q[$];
    rx_word_s   exp_q[$];
    rx_word_s   exp_w;
    rx_word_s   drv_w;

    int         cyc;
    int         limit;
    int         m;
    int         xfer_cyc;
    int         prev_xfer;
    int         tx_errs;
    int         rx_errs;
    int         seq_errs;
    logic       tx_busy;
    logic       held;
    logic       have_prev;
    data_t      cur_word;
    logic       cur_ferr;

    uart_sync_top dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .tx_data   (tx_data),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready),
        .txd       (txd),
        .rxd       (rxd),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .frame_err (frame_err)
    );

    // rxd follows txd in loopback, else the hand-built waveform
    assign rxd = loop_mode ? txd : rxd_drv;

    always #20 clk = ~clk;

    // line level expected in bit slot k of a frame
    function automatic logic frame_bit(input data_t w, input int k);
        if (k == 0) begin
            return 1'b0;
        end else if (k <= W) begin
            return w[k-1];
        end
        return 1'b1;
    endfunction

    always @(posedge clk) begin
        cyc = cyc + 1;
        if (limit > 0 && cyc > limit) begin
            $display("timeout: run still busy after %0d cycles", cyc);
            $display("SIMULATION FAILED");
            $finish;
        end else if (rst_n) begin
            // mid-bit samples counted from the transfer edge
            if (tx_busy) begin
                m = cyc - xfer_cyc - 1;
                if (m % D == D / 2 && txd !== frame_bit(cur_word, m / D)) begin
                    tx_errs++;
                    $display("error txd bit %0d of word %h: expected %h got %h",
                             m / D, cur_word, frame_bit(cur_word, m / D), txd);
                end
                if (m == BITS * D - 1) begin
                    tx_busy = 1'b0;
                end
            end
            if (rx_valid) begin
                if (exp_q.size() == 0) begin
                    seq_errs++;
                    $display("unexpected rx_valid pulse carrying %h", rx_data);
                end else begin
                    exp_w = exp_q.pop_front();
                    if (rx_data !== exp_w.data) begin
                        rx_errs++;
                        $display("error rx_data: expected %h got %h", exp_w.data, rx_data);
                    end
                    if (frame_err !== exp_w.frame_err) begin
                        rx_errs++;
                        $display("error frame_err: expected %h got %h",
                                 exp_w.frame_err, frame_err);
                    end
                end
            end
            if (!tx_valid) begin
                held = 1'b0;
            end
            if (tx_valid && tx_ready) begin
                if (have_prev && held && cyc - prev_xfer != BITS * D) begin
                    tx_errs++;
                    $display("error tx_ready: transfer spacing %h cycles, expected %h",
                             cyc - prev_xfer, BITS * D);
                end
                if (loop_mode) begin
                    if (exp_q.size() != 0) begin
                        seq_errs++;
                        $display("word %h not received before the next transfer",
                                 exp_q[0].data);
                        exp_q.delete();
                    end
                    exp_w.data      = tx_data;
                    exp_w.frame_err = cur_ferr;
                    exp_q.push_back(exp_w);
                end
                cur_word  = tx_data;
                xfer_cyc  = cyc;
                prev_xfer = cyc;
                tx_busy   = 1'b1;
                have_prev = 1'b1;
                held      = 1'b1;
            end
        end
    end

    task automatic check_idle_outputs();
        if (txd !== 1'b1) begin
            tx_errs++;
            $display("error txd: expected %h got %h", 1'b1, txd);
        end
        if (tx_ready !== 1'b1) begin
            tx_errs++;
            $display("error tx_ready: expected %h got %h", 1'b1, tx_ready);
        end
        if (rx_valid !== 1'b0) begin
            rx_errs++;
            $display("error rx_valid: expected %h got %h", 1'b0, rx_valid);
        end
    endtask

    task automatic load_items();
        int         fd;
        int         r;
        int         ch;
        logic [7:0] c;
        data_t      w;
        logic [3:0] f;
        fd = $fopen("uart_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open uart_stimulus.txt");
            return;
        end
        r = 1;
        while (r == 1) begin
            r = $fscanf(fd, " %c", c);
            if (r == 1 && c == "#") begin
                ch = $fgetc(fd);
                while (ch != 10 && ch != -1) begin
                    ch = $fgetc(fd);
                end
            end else if (r == 1) begin
                if ($fscanf(fd, " %h %h", w, f) != 2) begin
                    seq_errs++;
                    $display("malformed line in uart_stimulus.txt after %0d items",
                             mode_q.size());
                    r = 0;
                end else begin
                    mode_q.push_back(c);
                    word_q.push_back(w);
                    ferr_q.push_back(f[0]);
                end
            end
        end
        $fclose(fd);
    endtask

    // called on a falling edge, returns on the falling edge after the transfer
    task automatic send_loopback(input data_t w, input logic f);
        loop_mode = 1'b1;
        cur_ferr  = f;
        tx_data   = w;
        tx_valid  = 1'b1;
        while (!tx_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    task automatic settle_loopback();
        int n;
        tx_valid = 1'b0;
        while (!tx_ready) begin
            @(negedge clk);
        end
        n = 0;
        while (exp_q.size() != 0 && n < 2 * D) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            seq_errs++;
            $display("no rx_valid pulse arrived for word %h", exp_q[0].data);
            exp_q.delete();
        end
    endtask

    task automatic drive_bad_stop(input data_t w, input logic f);
        int i;
        loop_mode       = 1'b0;
        drv_w.data      = w;
        drv_w.frame_err = f;
        exp_q.push_back(drv_w);
        rxd_drv = 1'b0;
        repeat (D) @(negedge clk);
        for (i = 0; i < W; i++) begin
            rxd_drv = w[i];
            repeat (D) @(negedge clk);
        end
        // stop bit low
        rxd_drv = 1'b0;
        repeat (D) @(negedge clk);
        rxd_drv = 1'b1;
        repeat (BITS * D) @(negedge clk);
        if (exp_q.size() != 0) begin
            seq_errs++;
            $display("no rx_valid pulse for the bad-stop frame carrying %h", w);
            exp_q.delete();
        end
    endtask

    task automatic run_items();
        int   idx;
        int   gap;
        logic last_l;
        for (idx = 0; idx < mode_q.size(); idx++) begin
            if (mode_q[idx] == "L") begin
                send_loopback(word_q[idx], ferr_q[idx]);
                gap = $urandom % 8;
                if (gap < 4) begin
                    gap = 0;
                end
                last_l = (idx + 1 >= mode_q.size()) || (mode_q[idx+1] != "L");
                // gap 0 keeps tx_valid high so the next word waits on tx_ready
                if (gap != 0 || last_l) begin
                    tx_valid = 1'b0;
                    repeat (gap) @(negedge clk);
                end
            end else if (mode_q[idx] == "F") begin
                settle_loopback();
                drive_bad_stop(word_q[idx], ferr_q[idx]);
            end else if (mode_q[idx] == "G") begin
                settle_loopback();
                loop_mode = 1'b0;
                rxd_drv   = 1'b0;
                repeat (GLITCH) @(negedge clk);
                rxd_drv = 1'b1;
                repeat (12 * D) @(negedge clk);
            end else begin
                seq_errs++;
                $display("unknown mode in stimulus item %0d", idx);
            end
        end
        settle_loopback();
        repeat (2 * D) @(negedge clk);
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        tx_data   = '0;
        tx_valid  = 1'b0;
        rxd_drv   = 1'b1;
        loop_mode = 1'b1;
        cyc       = 0;
        limit     = 0;
        tx_errs   = 0;
        rx_errs   = 0;
        seq_errs  = 0;
        tx_busy   = 1'b0;
        held      = 1'b0;
        have_prev = 1'b0;
        cur_word  = '0;
        cur_ferr  = 1'b0;
        m         = $urandom(32'h44fd);
        load_items();
        if (mode_q.size() == 0) begin
            $display("no test items could be read from uart_stimulus.txt");
            $display("SIMULATION FAILED");
            $finish;
        end else begin
            limit = mode_q.size() * 14 * D + 200;
            repeat (2) begin
                @(negedge clk);
                check_idle_outputs();
            end
            rst_n = 1'b1;
            @(negedge clk);
            check_idle_outputs();
            run_items();
            $display("errors: tx %0d rx %0d sequence %0d", tx_errs, rx_errs, seq_errs);
            if (tx_errs + rx_errs + seq_errs == 0) begin
                $display("SIMULATION PASSED");
            end else begin
                $display("SIMULATION FAILED");
            end
            $finish;
        end
    end

endmodule

/* uart_sync_top.sv */
// UART top level
`timescale 1ns/1ps

module uart_sync_top (
    input  logic            clk,
    input  logic            rst_n,
    input  uart_pkg::data_t tx_data,
    input  logic            tx_valid,
    output logic            tx_ready,
    output logic            txd,
    input  logic            rxd,
    output uart_pkg::data_t rx_data,
    output logic            rx_valid,
    output logic            frame_err
);
    import uart_pkg::*;

    logic       tx_run;
    logic       tx_tick;
    shift_ctl_s tx_ctl;

    logic       rx_run;
    logic       rx_half;
    logic       rx_tick;
    logic       rx_fall;
    logic       rx_level;
    logic       rx_stop_bad;
    shift_ctl_s rx_ctl;
    rx_word_s   rx_word;

    // transmit path
    uart_bit_timer u_tx_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .run   (tx_run),
        .half  (1'b0),
        .tick  (tx_tick)
    );

    uart_tx_ctrl u_tx_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .tick     (tx_tick),
        .run      (tx_run),
        .ctl      (tx_ctl)
    );

    uart_tx_shift u_tx_shift (
        .clk     (clk),
        .rst_n   (rst_n),
        .tx_data (tx_data),
        .ctl     (tx_ctl),
        .txd     (txd)
    );

    // receive path
    uart_bit_timer u_rx_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .run   (rx_run),
        .half  (rx_half),
        .tick  (rx_tick)
    );

    uart_rx_ctrl u_rx_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .fall     (rx_fall),
        .rxd_s    (rx_level),
        .tick     (rx_tick),
        .run      (rx_run),
        .half     (rx_half),
        .ctl      (rx_ctl),
        .stop_bad (rx_stop_bad)
    );

    uart_rx_shift u_rx_shift (
        .clk      (clk),
        .rst_n    (rst_n),
        .rxd      (rxd),
        .ctl      (rx_ctl),
        .stop_bad (rx_stop_bad),
        .fall     (rx_fall),
        .rxd_s    (rx_level),
        .rx_word  (rx_word),
        .rx_valid (rx_valid)
    );

    assign rx_data   = rx_word.data;
    assign frame_err = rx_word.frame_err;

endmodule

/* uart_rx_shift.sv */
// UART receive synchronizer and shift register
`timescale 1ns/1ps
`include "uart_config.svh"

module uart_rx_shift (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 rxd,
    input  uart_pkg::shift_ctl_s ctl,
    input  logic                 stop_bad,
    output logic                 fall,
    output logic                 rxd_s,
    output uart_pkg::rx_word_s   rx_word,
    output logic                 rx_valid
);
    import uart_pkg::*;

    logic  rxd_meta;
    logic  rxd_d;
    data_t data_sr;

    assign fall = rxd_d & ~rxd_s;

    // two-stage sync, plus one more stage for edge detect
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rxd_meta <= 1'b1;
            rxd_s    <= 1'b1;
            rxd_d    <= 1'b1;
            rx_word  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rxd_meta <= rxd;
            rxd_s    <= rxd_meta;
            rxd_d    <= rxd_s;
            rx_valid <= ctl.load;
            if (ctl.load) begin
                rx_word.data      <= data_sr;
                rx_word.frame_err <= stop_bad;
            end
        end
    end

    // lsb arrives first and ends up at bit 0
    always_ff @(posedge clk) begin
        if (ctl.shift) begin
            data_sr <= {rxd_s, data_sr[`UART_DATA_WIDTH-1:1]};
        end
    end

endmodule

/* uart_rx_ctrl.sv */
// UART receive control FSM
`timescale 1ns/1ps
`include "uart_config.svh"

module uart_rx_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 fall,
    input  logic                 rxd_s,
    input  logic                 tick,
    output logic                 run,
    output logic                 half,
    output uart_pkg::shift_ctl_s ctl,
    output logic                 stop_bad
);
    import uart_pkg::*;

    localparam bit_cnt_t LAST_BIT = bit_cnt_t'(`UART_DATA_WIDTH - 1);

    rx_state_e state_q;
    bit_cnt_t  bit_cnt_q;

    assign run  = (state_q != RX_IDLE);
    // timer takes this only in its first run cycle
    assign half = (state_q == RX_START);

    // every tick after the start check lands mid-bit
    assign ctl.shift = tick & (state_q == RX_DATA);
    assign ctl.load  = tick & (state_q == RX_STOP);
    assign stop_bad  = (state_q == RX_STOP) & ~rxd_s;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= RX_IDLE;
            bit_cnt_q <= '0;
        end else begin
            case (state_q)
                RX_IDLE: begin
                    if (fall) begin
                        state_q <= RX_START;
                    end
                end
                RX_START: begin
                    if (tick) begin
                        // line back high at mid start bit means a glitch
                        if (!rxd_s) begin
                            state_q   <= RX_DATA;
                            bit_cnt_q <= '0;
                        end else begin
                            state_q <= RX_IDLE;
                        end
                    end
                end
                RX_DATA: begin
                    if (tick) begin
                        if (bit_cnt_q == LAST_BIT) begin
                            state_q <= RX_STOP;
                        end else begin
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                        end
                    end
                end
                RX_STOP: begin
                    // idle from mid stop bit, ready for the next fall
                    if (tick) begin
                        state_q <= RX_IDLE;
                    end
                end
                default: begin
                    state_q <= RX_IDLE;
                end
            endcase
        end
    end

endmodule

/* uart_tx_shift.sv */
// UART transmit shift register
`timescale 1ns/1ps
`include "uart_config.svh"

module uart_tx_shift (
    input  logic                 clk,
    input  logic                 rst_n,
    input  uart_pkg::data_t      tx_data,
    input  uart_pkg::shift_ctl_s ctl,
    output logic                 txd
);
    import uart_pkg::*;

    frame_t frame_q;

    // ones shift in from the top so the line rests high after stop
    always_ff @(posedge clk) begin
        if (ctl.load) begin
            frame_q <= {1'b1, tx_data, 1'b0};
        end else if (ctl.shift) begin
            frame_q <= {1'b1, frame_q[`UART_DATA_WIDTH+1:1]};
        end
    end

    // registered line driver
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            txd <= 1'b1;
        end else if (ctl.load) begin
            txd <= 1'b0;
        end else if (ctl.shift) begin
            txd <= frame_q[1];
        end
    end

endmodule

/* uart_tx_ctrl.sv */
// UART transmit control FSM
`timescale 1ns/1ps
`include "uart_config.svh"

module uart_tx_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                tx_valid,
    output logic                tx_ready,
    input  logic                tick,
    output logic                run,
    output uart_pkg::shift_ctl_s ctl
);
    import uart_pkg::*;

    localparam bit_cnt_t LAST_BIT = bit_cnt_t'(`UART_DATA_WIDTH - 1);

    tx_state_e state_q;
    bit_cnt_t  bit_cnt_q;

    // ready again in the last cycle of the stop bit, so frames can abut
    assign tx_ready = (state_q == TX_IDLE) || ((state_q == TX_STOP) && tick);
    assign run      = (state_q != TX_IDLE);

    assign ctl.load  = tx_valid & tx_ready;
    assign ctl.shift = run & tick;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= TX_IDLE;
            bit_cnt_q <= '0;
        end else begin
            case (state_q)
                TX_IDLE: begin
                    if (ctl.load) begin
                        state_q <= TX_START;
                    end
                end
                TX_START: begin
                    if (tick) begin
                        state_q   <= TX_DATA;
                        bit_cnt_q <= '0;
                    end
                end
                TX_DATA: begin
                    if (tick) begin
                        if (bit_cnt_q == LAST_BIT) begin
                            state_q <= TX_STOP;
                        end else begin
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                        end
                    end
                end
                TX_STOP: begin
                    if (tick) begin
                        // a waiting word goes straight into its start bit
                        if (ctl.load) begin
                            state_q <= TX_START;
                        end else begin
                            state_q <= TX_IDLE;
                        end
                    end
                end
                default: begin
                    state_q <= TX_IDLE;
                end
            endcase
        end
    end

endmodule

/* uart_bit_timer.sv */
// UART bit period timer
`timescale 1ns/1ps
`include "uart_config.svh"

module uart_bit_timer (
    input  logic clk,
    input  logic rst_n,
    input  logic run,
    input  logic half,
    output logic tick
);
    import uart_pkg::*;

    localparam baud_cnt_t FULL_TERM = baud_cnt_t'(`UART_CLK_DIVISOR - 1);
    localparam baud_cnt_t HALF_TERM = baud_cnt_t'(`UART_CLK_DIVISOR / 2 - 1);

    baud_cnt_t cnt_q;
    baud_cnt_t term;
    logic      run_q;
    logic      half_q;
    logic      first;
    logic      half_sel;

    // half mode is picked up in the first run cycle only
    assign first    = run & ~run_q;
    assign half_sel = first ? half : half_q;
    assign term     = half_sel ? HALF_TERM : FULL_TERM;
    assign tick     = run & (cnt_q == term);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q  <= '0;
            run_q  <= 1'b0;
            half_q <= 1'b0;
        end else begin
            run_q <= run;
            if (!run || tick) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
            // later periods are always full
            if (!run || tick) begin
                half_q <= 1'b0;
            end else if (first) begin
                half_q <= half;
            end
        end
    end

endmodule

/* uart_pkg.sv */
// UART shared types
`include "uart_config.svh"

package uart_pkg;

    // one data word
    typedef logic [`UART_DATA_WIDTH-1:0] data_t;

    // bit timer count, holds divisor minus one
    typedef logic [$clog2(`UART_CLK_DIVISOR)-1:0] baud_cnt_t;

    // data bit index within a frame
    typedef logic [3:0] bit_cnt_t;

    // stop, data and start bits of one transmit frame
    typedef logic [`UART_DATA_WIDTH+1:0] frame_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    // strobes from an FSM to its datapath
    typedef struct packed {
        logic load;
        logic shift;
    } shift_ctl_s;

    typedef struct packed {
        data_t data;
        logic  frame_err;
    } rx_word_s;

endpackage

/* uart_config.svh */
// UART build configuration
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// data bits per frame
`define UART_DATA_WIDTH 8

// clock cycles per bit, must be even and at least 4
// 16 keeps simulation short, 868 gives 115200 baud from 100 MHz
`define UART_CLK_DIVISOR 16

`endif
